/* logic/sampleFormatPkg.sv */
`default_nettype none

package sampleFormatPkg;

    // raw sample word width
    localparam int SAMPLE_WIDTH = 12;
    // bits per bin field for 16 bins
    localparam int BIN_WIDTH = 4;
    // bits below the fine field
    localparam int RESIDUE_WIDTH = 4;
    localparam int NUM_BINS = 1 << BIN_WIDTH;

    typedef logic [BIN_WIDTH-1:0] binIndex_t;

    // coarse pass sees only the top field
    typedef struct packed {
        binIndex_t coarseBin;
        logic [SAMPLE_WIDTH-BIN_WIDTH-1:0] remainder;
    } coarseView_t;

    // fine pass splits the remainder further
    typedef struct packed {
        binIndex_t windowTag;
        binIndex_t fineBin;
        logic [RESIDUE_WIDTH-1:0] residue;
    } fineView_t;

    // one sample word with two decodes
    typedef union packed {
        coarseView_t coarse;
        fineView_t fine;
    } sampleWord_u;

endpackage

`default_nettype wire

/* logic/histPhasePkg.sv */
`default_nettype none

package histPhasePkg;

    // acquisition phases of the two-pass histogram
    // idle until start
    // coarse counts the top bin field
    // fine counts inside the coarse peak window
    // scan wait covers drain and peak scan
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        COARSE    = 2'd1,
        FINE      = 2'd2,
        SCAN_WAIT = 2'd3
    } phase_e;

    // counter width when nothing overrides it
    localparam int DEFAULT_COUNT_WIDTH = 8;

endpackage

`default_nettype wire

/* logic/binDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module binDecoder (
    input wire clk,
    input wire rst,
    input wire sampleValid,
    input wire sampleFormatPkg::sampleWord_u sample,
    input wire histPhasePkg::phase_e phase,
    input wire sampleFormatPkg::binIndex_t coarsePeak,
    output logic binValid,
    output sampleFormatPkg::binIndex_t binIndex,
    output logic sampleSeen
);

    logic accept;
    logic inWindow;

    // strobe taken only in an acquiring phase
    assign accept = sampleValid &&
        (phase == histPhasePkg::COARSE || phase == histPhasePkg::FINE);

    // fine pass window is the coarse peak bin
    assign inWindow = (sample.fine.windowTag == coarsePeak);

    // every accepted strobe counts toward the pass length
    assign sampleSeen = accept;

    always_ff @(posedge clk) begin
        if (rst) begin
            binValid <= 1'b0;
        end else begin
            // out of window samples give no bin
            binValid <= accept && (phase == histPhasePkg::COARSE || inWindow);
        end
    end

    // bin field picked by phase one cycle behind the strobe
    always_ff @(posedge clk) begin
        if (accept) begin
            if (phase == histPhasePkg::FINE) begin
                binIndex <= sample.fine.fineBin;
            end else begin
                binIndex <= sample.coarse.coarseBin;
            end
        end
    end

    // builder holds the phase through the drain cycle
    binOnlyWhileAcquiring: assert property (@(posedge clk) disable iff (rst)
        binValid |-> (phase == histPhasePkg::COARSE || phase == histPhasePkg::FINE))
        else $error("binDecoder: binValid in idle or scan phase");

endmodule

`default_nettype wire

/* logic/histogramBuilder.sv */
`timescale 1ns/1ps
`default_nettype none

module histogramBuilder #(
    parameter int samplesPerPass = 20,
    parameter int countWidth = histPhasePkg::DEFAULT_COUNT_WIDTH
) (
    input wire clk,
    input wire rst,
    input wire start,
    input wire binValid,
    input wire sampleFormatPkg::binIndex_t binIndex,
    input wire sampleSeen,
    input wire peakValid,
    output histPhasePkg::phase_e phase,
    output logic acquiring,
    output logic scanStart,
    output logic [sampleFormatPkg::NUM_BINS*countWidth-1:0] countBank
);

    localparam int strobeWidth = $clog2(samplesPerPass + 1);
    localparam logic [countWidth-1:0] countMax = '1;

    logic [strobeWidth-1:0] strobeCount;
    logic fineScan;
    logic clearBank;
    logic lastStrobe;
    logic [countWidth-1:0] binCount;

    // count of the bin being hit
    assign binCount = countBank[binIndex*countWidth +: countWidth];

    // final strobe of this pass
    assign lastStrobe = sampleSeen && (strobeCount == strobeWidth'(samplesPerPass - 1));

    // bank cleared when a pass opens
    assign clearBank = (phase == histPhasePkg::IDLE && start) ||
        (phase == histPhasePkg::SCAN_WAIT && peakValid && !fineScan);

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= histPhasePkg::IDLE;
            acquiring <= 1'b0;
            scanStart <= 1'b0;
            fineScan <= 1'b0;
            strobeCount <= '0;
        end else begin
            scanStart <= 1'b0;
            // strobes arrive only while acquiring
            if (sampleSeen) begin
                strobeCount <= strobeCount + 1'b1;
            end
            if (lastStrobe) begin
                acquiring <= 1'b0;
            end
            case (phase)
                histPhasePkg::IDLE: begin
                    if (start) begin
                        phase <= histPhasePkg::COARSE;
                        acquiring <= 1'b1;
                        strobeCount <= '0;
                    end
                end
                histPhasePkg::COARSE, histPhasePkg::FINE: begin
                    // one drain cycle for the last increment
                    if (!acquiring) begin
                        phase <= histPhasePkg::SCAN_WAIT;
                        scanStart <= 1'b1;
                        fineScan <= (phase == histPhasePkg::FINE);
                    end
                end
                histPhasePkg::SCAN_WAIT: begin
                    if (peakValid) begin
                        if (fineScan) begin
                            phase <= histPhasePkg::IDLE;
                        end else begin
                            // coarse peak known so the fine pass opens
                            phase <= histPhasePkg::FINE;
                            acquiring <= 1'b1;
                            strobeCount <= '0;
                        end
                    end
                end
                default: phase <= histPhasePkg::IDLE;
            endcase
        end
    end

    // saturating bin counters
    always_ff @(posedge clk) begin
        if (clearBank) begin
            countBank <= '0;
        end else if (binValid && binCount != countMax) begin
            countBank[binIndex*countWidth +: countWidth] <= binCount + 1'b1;
        end
    end

    // acquiring must close before the pass overruns
    strobeBound: assert property (@(posedge clk) disable iff (rst)
        strobeCount <= strobeWidth'(samplesPerPass))
        else $error("histogramBuilder: accepted strobes exceed pass length");

endmodule

`default_nettype wire

/* logic/peakDetector.sv */
`timescale 1ns/1ps
`default_nettype none

module peakDetector #(
    parameter int countWidth = histPhasePkg::DEFAULT_COUNT_WIDTH
) (
    input wire clk,
    input wire rst,
    input wire scanStart,
    input wire [sampleFormatPkg::NUM_BINS*countWidth-1:0] countBank,
    output logic peakValid,
    output sampleFormatPkg::binIndex_t peakIndex,
    output logic [countWidth-1:0] peakCountOut
);

    localparam sampleFormatPkg::binIndex_t lastBin =
        sampleFormatPkg::binIndex_t'(sampleFormatPkg::NUM_BINS - 1);

    logic scanning;
    sampleFormatPkg::binIndex_t scanIdx;
    logic [countWidth-1:0] scanCount;
    logic better;

    // bin under inspection this cycle
    assign scanCount = countBank[scanIdx*countWidth +: countWidth];

    // strictly greater so lower bins keep ties
    assign better = scanCount > peakCountOut;

    always_ff @(posedge clk) begin
        if (rst) begin
            scanning <= 1'b0;
            scanIdx <= '0;
            peakValid <= 1'b0;
        end else begin
            peakValid <= 1'b0;
            if (scanStart) begin
                scanning <= 1'b1;
                scanIdx <= '0;
            end else if (scanning) begin
                scanIdx <= scanIdx + 1'b1;
                // result ready the cycle after the last bin
                if (scanIdx == lastBin) begin
                    scanning <= 1'b0;
                    peakValid <= 1'b1;
                end
            end
        end
    end

    // running best seeded at bin 0 with zero
    always_ff @(posedge clk) begin
        if (scanStart) begin
            peakIndex <= '0;
            peakCountOut <= '0;
        end else if (scanning && better) begin
            peakIndex <= scanIdx;
            peakCountOut <= scanCount;
        end
    end

    // builder launches one scan at a time
    noOverlappedScan: assert property (@(posedge clk) disable iff (rst)
        scanStart |-> !scanning)
        else $error("peakDetector: scanStart during a running scan");

endmodule

`default_nettype wire

/* logic/peakResult.sv */
`timescale 1ns/1ps
`default_nettype none

module peakResult #(
    parameter int countWidth = histPhasePkg::DEFAULT_COUNT_WIDTH
) (
    input wire clk,
    input wire rst,
    input wire peakValid,
    input wire sampleFormatPkg::binIndex_t peakIndex,
    input wire [countWidth-1:0] peakCountOut,
    input wire histPhasePkg::phase_e phase,
    output sampleFormatPkg::binIndex_t coarsePeak,
    output logic done,
    output logic [sampleFormatPkg::SAMPLE_WIDTH-1:0] peakValue,
    output sampleFormatPkg::binIndex_t coarseBin,
    output sampleFormatPkg::binIndex_t fineBin,
    output logic [countWidth-1:0] peakCount
);

    // middle of a fine bin is binary 1000
    localparam logic [sampleFormatPkg::RESIDUE_WIDTH-1:0] midResidue =
        {1'b1, {(sampleFormatPkg::RESIDUE_WIDTH-1){1'b0}}};

    logic finePass;
    sampleFormatPkg::sampleWord_u peakWord;

    always_ff @(posedge clk) begin
        if (rst) begin
            finePass <= 1'b0;
            done <= 1'b0;
        end else begin
            // remember which pass the scan belongs to
            if (phase == histPhasePkg::COARSE) begin
                finePass <= 1'b0;
            end else if (phase == histPhasePkg::FINE) begin
                finePass <= 1'b1;
            end
            done <= peakValid && finePass;
        end
    end

    always_ff @(posedge clk) begin
        if (peakValid && !finePass) begin
            coarseBin <= peakIndex;
        end
        if (peakValid && finePass) begin
            fineBin <= peakIndex;
            peakCount <= peakCountOut;
        end
    end

    // coarse peak sets the fine window
    assign coarsePeak = coarseBin;

    // rebuild a sample word from both bins
    always_comb begin
        peakWord.fine.windowTag = coarseBin;
        peakWord.fine.fineBin = fineBin;
        peakWord.fine.residue = midResidue;
    end

    assign peakValue = peakWord;

endmodule

`default_nettype wire

/* logic/sifhPeakTop.sv */
`timescale 1ns/1ps
`default_nettype none

module sifhPeakTop #(
    parameter int samplesPerPass = 20,
    parameter int countWidth = 4
) (
    input wire clk,
    input wire rst,
    input wire start,
    input wire sampleValid,
    input wire [sampleFormatPkg::SAMPLE_WIDTH-1:0] sample,
    output logic acquiring,
    output logic done,
    output logic [sampleFormatPkg::SAMPLE_WIDTH-1:0] peakValue,
    output sampleFormatPkg::binIndex_t coarseBin,
    output sampleFormatPkg::binIndex_t fineBin,
    output logic [countWidth-1:0] peakCount
);

    logic sampleGated;
    logic binValid;
    sampleFormatPkg::binIndex_t binIndex;
    logic sampleSeen;
    histPhasePkg::phase_e phase;
    sampleFormatPkg::binIndex_t coarsePeak;
    logic scanStart;
    logic [sampleFormatPkg::NUM_BINS*countWidth-1:0] countBank;
    logic peakValid;
    sampleFormatPkg::binIndex_t peakIndex;
    logic [countWidth-1:0] peakCountOut;

    // strobes outside acquisition are dropped here
    assign sampleGated = sampleValid & acquiring;

    binDecoder decodeU0 (
        .clk(clk),
        .rst(rst),
        .sampleValid(sampleGated),
        .sample(sample),
        .phase(phase),
        .coarsePeak(coarsePeak),
        .binValid(binValid),
        .binIndex(binIndex),
        .sampleSeen(sampleSeen)
    );

    histogramBuilder #(
        .samplesPerPass(samplesPerPass),
        .countWidth(countWidth)
    ) builderU0 (
        .clk(clk),
        .rst(rst),
        .start(start),
        .binValid(binValid),
        .binIndex(binIndex),
        .sampleSeen(sampleSeen),
        .peakValid(peakValid),
        .phase(phase),
        .acquiring(acquiring),
        .scanStart(scanStart),
        .countBank(countBank)
    );

    peakDetector #(
        .countWidth(countWidth)
    ) detectU0 (
        .clk(clk),
        .rst(rst),
        .scanStart(scanStart),
        .countBank(countBank),
        .peakValid(peakValid),
        .peakIndex(peakIndex),
        .peakCountOut(peakCountOut)
    );

    // result side also feeds the decoder window
    peakResult #(
        .countWidth(countWidth)
    ) resultU0 (
        .clk(clk),
        .rst(rst),
        .peakValid(peakValid),
        .peakIndex(peakIndex),
        .peakCountOut(peakCountOut),
        .phase(phase),
        .coarsePeak(coarsePeak),
        .done(done),
        .peakValue(peakValue),
        .coarseBin(coarseBin),
        .fineBin(fineBin),
        .peakCount(peakCount)
    );

endmodule

`default_nettype wire

/* verification/sifhPeakTests.svh */
`ifndef SIFH_PEAK_TESTS_SVH
`define SIFH_PEAK_TESTS_SVH

    task automatic waitAcquiring(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (acquiring !== level) begin
            if (cycles == WAIT_LIMIT) begin
                $display("timeout: acquiring never went to %b", level);
                stopOnError();
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic waitDone();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (done !== 1'b1) begin
            if (cycles == WAIT_LIMIT) begin
                $display("timeout: done pulse never came");
                stopOnError();
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic pulseStart();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic fillSamples(input bit finePass, input int first, input int num,
        input logic [11:0] value);
        int i;
        for (i = first; i < first + num; i++) begin
            if (finePass) begin
                fineSet[i] = value;
            end else begin
                coarseSet[i] = value;
            end
        end
    endtask

    // one strobe per cycle then optional strobes after acquiring drops
    task automatic feedPass(input bit finePass, input int junkCycles,
        input logic [11:0] junkValue);
        int i;
        waitAcquiring(1'b1);
        for (i = 0; i < PASS_LEN; i++) begin
            @(posedge clk);
            sampleValid <= 1'b1;
            sample <= finePass ? fineSet[i] : coarseSet[i];
        end
        for (i = 0; i < junkCycles; i++) begin
            @(posedge clk);
            sampleValid <= 1'b1;
            sample <= junkValue;
        end
        @(posedge clk);
        sampleValid <= 1'b0;
    endtask

    task automatic runAndCheck(input string name, input int junkCycles,
        input logic [11:0] coarseJunk, input logic [11:0] fineJunk);
        int cIdx;
        int fIdx;
        int fCnt;
        sampleFormatPkg::sampleWord_u expValue;
        modelRun(cIdx, fIdx, fCnt);
        // coarse bin then fine bin then middle of the fine bin
        expValue = {4'(cIdx), 4'(fIdx), 4'b1000};
        pulseStart();
        feedPass(1'b0, junkCycles, coarseJunk);
        feedPass(1'b1, junkCycles, fineJunk);
        waitDone();
        compareBin(coarseBin, 4'(cIdx), {name, ": coarseBin"});
        compareBin(fineBin, 4'(fIdx), {name, ": fineBin"});
        compareCount(peakCount, 4'(fCnt), {name, ": peakCount"});
        compareValue(peakValue, expValue, {name, ": peakValue"});
        compareLevel(acquiring, 1'b0, {name, ": acquiring after done"});
        comparePhase(uut.phase, histPhasePkg::IDLE, {name, ": phase after done"});
    endtask

    task automatic testConstant();
        fillSamples(1'b0, 0, PASS_LEN, 12'h5A3);
        fillSamples(1'b1, 0, PASS_LEN, 12'h5A3);
        runAndCheck("constant", 0, '0, '0);
        // 20 hits stop at the ceiling
        compareCount(peakCount, 4'd15, "constant: saturated count");
    endtask

    task automatic testClusters();
        fillSamples(1'b0, 0, 4, 12'h9A0);
        fillSamples(1'b0, 4, 12, 12'h345);
        fillSamples(1'b0, 16, 4, 12'h9A0);
        fillSamples(1'b1, 0, 5, 12'h31E);
        fillSamples(1'b1, 5, 9, 12'h36F);
        fillSamples(1'b1, 14, 6, 12'h3C1);
        runAndCheck("two clusters", 0, '0, '0);
    endtask

    // out of window majority must not win the fine pass
    task automatic testWindow();
        fillSamples(1'b0, 0, 14, 12'hB11);
        fillSamples(1'b0, 14, 6, 12'h2FF);
        fillSamples(1'b1, 0, 12, 12'h274);
        fillSamples(1'b1, 12, 5, 12'hB48);
        fillSamples(1'b1, 17, 3, 12'hBE0);
        runAndCheck("window", 0, '0, '0);
    endtask

    // higher bins arrive first in both passes
    task automatic testTies();
        fillSamples(1'b0, 0, 10, 12'hA00);
        fillSamples(1'b0, 10, 10, 12'h6FF);
        fillSamples(1'b1, 0, 7, 12'h6D0);
        fillSamples(1'b1, 7, 7, 12'h620);
        fillSamples(1'b1, 14, 6, 12'hA20);
        runAndCheck("ties", 0, '0, '0);
    endtask

    task automatic testIgnoreAndReset();
        int i;
        // strobes in idle
        for (i = 0; i < 4; i++) begin
            @(posedge clk);
            sampleValid <= 1'b1;
            sample <= 12'hF20;
        end
        @(posedge clk);
        sampleValid <= 1'b0;
        @(negedge clk);
        compareLevel(acquiring, 1'b0, "idle strobes: acquiring");
        // abort the coarse pass part way
        pulseStart();
        waitAcquiring(1'b1);
        for (i = 0; i < 8; i++) begin
            @(posedge clk);
            sampleValid <= 1'b1;
            sample <= 12'hF20;
        end
        @(posedge clk);
        rst <= 1'b1;
        sampleValid <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compareLevel(acquiring, 1'b0, "mid reset: acquiring");
        compareLevel(done, 1'b0, "mid reset: done");
        comparePhase(uut.phase, histPhasePkg::IDLE, "mid reset: phase");
        // late strobes would tip both passes if counted
        fillSamples(1'b0, 0, 7, 12'h250);
        fillSamples(1'b0, 7, 6, 12'hF10);
        fillSamples(1'b0, 13, 7, 12'h530);
        fillSamples(1'b1, 0, 4, 12'h250);
        fillSamples(1'b1, 4, 3, 12'h2A0);
        fillSamples(1'b1, 7, 13, 12'h700);
        runAndCheck("late strobes after reset", 6, 12'hF20, 12'h2A0);
    endtask

    // coarse bins 4 and 5 only
    task automatic testRandom();
        int round;
        int i;
        int r;
        for (round = 0; round < 3; round++) begin
            for (i = 0; i < PASS_LEN; i++) begin
                r = $random(seed);
                coarseSet[i] = 12'h400 | 12'(r & 32'h1FF);
                r = $random(seed);
                fineSet[i] = 12'h400 | 12'(r & 32'h1FF);
            end
            runAndCheck($sformatf("random round %0d", round), 0, '0, '0);
        end
    endtask

`endif

/* verification/sifhPeakTb.sv */
`timescale 1ns/1ps
`default_nettype none

module sifhPeakTb;

    // pass length and count ceiling of the DUT as the top builds it
    localparam int PASS_LEN = 20;
    localparam int COUNT_SAT = 15;
    // longest any single wait may take, in cycles
    localparam int WAIT_LIMIT = 100;

    logic clk;
    logic rst;
    logic start;
    logic sampleValid;
    logic [sampleFormatPkg::SAMPLE_WIDTH-1:0] sample;
    logic acquiring;
    logic done;
    logic [sampleFormatPkg::SAMPLE_WIDTH-1:0] peakValue;
    sampleFormatPkg::binIndex_t coarseBin;
    sampleFormatPkg::binIndex_t fineBin;
    logic [3:0] peakCount;

    integer seed;

    // stimulus of one run for the coarse pass then the fine pass
    logic [11:0] coarseSet [PASS_LEN];
    logic [11:0] fineSet [PASS_LEN];
    // software histogram of the reference model
    int histModel [16];

    sifhPeakTop uut (
        .clk(clk),
        .rst(rst),
        .start(start),
        .sampleValid(sampleValid),
        .sample(sample),
        .acquiring(acquiring),
        .done(done),
        .peakValue(peakValue),
        .coarseBin(coarseBin),
        .fineBin(fineBin),
        .peakCount(peakCount)
    );

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic stopOnError();
        $display("Testbench failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compareBin(input sampleFormatPkg::binIndex_t got,
        input sampleFormatPkg::binIndex_t expected, input string what);
        if (got !== expected) begin
            $display("[FAIL] t=%0d ns: %s is %0d, expected %0d", $time, what, got, expected);
            stopOnError();
        end
    endtask

    task automatic compareValue(input sampleFormatPkg::sampleWord_u got,
        input sampleFormatPkg::sampleWord_u expected, input string what);
        if (got !== expected) begin
            $display("[FAIL] t=%0d ns: %s is %h, expected %h", $time, what, got, expected);
            stopOnError();
        end
    endtask

    task automatic compareCount(input logic [3:0] got, input logic [3:0] expected,
        input string what);
        if (got !== expected) begin
            $display("[FAIL] t=%0d ns: %s is %0d, expected %0d", $time, what, got, expected);
            stopOnError();
        end
    endtask

    task automatic compareLevel(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            $display("[FAIL] t=%0d ns: %s is %b, expected %b", $time, what, got, expected);
            stopOnError();
        end
    endtask

    task automatic comparePhase(input histPhasePkg::phase_e got,
        input histPhasePkg::phase_e expected, input string what);
        if (got !== expected) begin
            $display("[FAIL] t=%0d ns: %s is %s, expected %s", $time, what, got.name(),
                expected.name());
            stopOnError();
        end
    endtask

    task automatic clearHist();
        int b;
        for (b = 0; b < 16; b++) begin
            histModel[b] = 0;
        end
    endtask

    // counts stop at the ceiling
    task automatic addToHist(input int b);
        if (histModel[b] < COUNT_SAT) begin
            histModel[b] = histModel[b] + 1;
        end
    endtask

    // largest count with the lowest bin winning a tie
    task automatic pickPeak(output int idx, output int cnt);
        int b;
        idx = 0;
        cnt = 0;
        for (b = 0; b < 16; b++) begin
            if (histModel[b] > cnt) begin
                idx = b;
                cnt = histModel[b];
            end
        end
    endtask

    // both passes of one run in software
    task automatic modelRun(output int cIdx, output int fIdx, output int fCnt);
        int i;
        int cCnt;
        clearHist();
        for (i = 0; i < PASS_LEN; i++) begin
            addToHist(int'(coarseSet[i][11:8]));
        end
        pickPeak(cIdx, cCnt);
        clearHist();
        for (i = 0; i < PASS_LEN; i++) begin
            // fine pass counts only the coarse peak window
            if (int'(fineSet[i][11:8]) == cIdx) begin
                addToHist(int'(fineSet[i][7:4]));
            end
        end
        pickPeak(fIdx, fCnt);
    endtask

    `include "sifhPeakTests.svh"

    initial begin
        seed = 32'h906e;
        rst = 1'b1;
        start = 1'b0;
        sampleValid = 1'b0;
        sample = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        testConstant();
        testClusters();
        testWindow();
        testTies();
        testIgnoreAndReset();
        testRandom();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sifhPeak.f */
+incdir+verification
logic/sampleFormatPkg.sv
logic/histPhasePkg.sv
logic/binDecoder.sv
logic/histogramBuilder.sv
logic/peakDetector.sv
logic/peakResult.sv
logic/sifhPeakTop.sv
verification/sifhPeakTb.sv

/* run.sh */
#!/bin/sh
# compile and run the sifhPeak testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f sifhPeak.f --top-module sifhPeakTb -o sifhPeakSim
# a stop on the first error exits non-zero, so the log is searched instead
./obj_dir/sifhPeakSim > sim.log 2>&1 || true
cat sim.log
if grep -q "Testbench failed" sim.log; then
    exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
